//--- files.f
verilog/kalman_pkg.sv
verilog/addr_gen.sv
verilog/addr_stage.sv
verilog/dp_ram.sv
verilog/harmonics_sequencer.sv
verilog/rotate_update_alu.sv
verilog/kalman_harmonics_top.sv
tb/kalman_tb.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the testbench, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module kalman_tb -f files.f \
	-o kalman_sim \
	&& ./obj_dir/kalman_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -qx '\*\* PASS \*\*' sim.log && exit 0 || exit 1

//--- tb/kalman_tb.sv
`timescale 1ns/1ps

module kalman_tb;
	import kalman_pkg::*;

	localparam int HARMONICS_NUM = 5;
	localparam int SERIES_NUM = 4;
	localparam int ST_ADDR_W = $clog2(SERIES_NUM * HARMONICS_NUM * STATE_STRIDE);
	localparam int CF_ADDR_W = $clog2(HARMONICS_NUM * COEF_STRIDE + SERIES_NUM);
	localparam int N_COEF = COEF_STRIDE * HARMONICS_NUM;
	localparam int N_STATE = STATE_STRIDE * HARMONICS_NUM * SERIES_NUM;
	localparam int MAX_TESTS = 8;
	localparam int CLEAR_LEN = STATE_STRIDE * HARMONICS_NUM * SERIES_NUM;
	// Issue cycles of one frame plus drain and the ack cycle
	localparam int FRAME_LEN = SERIES_NUM * (6 * HARMONICS_NUM + 2) + PIPE_DEPTH + 1;
	localparam int WR_PER_SERIES = 4 * HARMONICS_NUM;
	localparam int NO_WRITE = 32'h7fffffff;

	logic clk;
	logic harmonics_rst;
	logic run_req_i;
	logic run_ack_o;
	logic coef_we_i;
	logic [CF_ADDR_W-1:0] coef_addr_i;
	coef_t coef_data_i;
	logic state_we_o;
	logic [ST_ADDR_W-1:0] state_addr_o;
	data_t state_data_o;

	string test_name [MAX_TESTS];
	int coef_tab [MAX_TESTS][N_COEF];
	int input_tab [MAX_TESTS][SERIES_NUM];
	int expect_tab [MAX_TESTS][N_STATE];
	int n_tests;

	int final_state [N_STATE];
	int checks;
	int errors;
	int cycles;
	int cycle_limit;
	int clear_count;
	int frame_writes;
	logic clear_done;
	logic in_frame;
	logic zero_frame;
	logic ack_prev;
	logic req_prev;

	kalman_harmonics_top #(.HARMONICS_NUM(HARMONICS_NUM), .SERIES_NUM(SERIES_NUM)) i_dut (
		.clk(clk), .harmonics_rst(harmonics_rst), .run_req_i(run_req_i),
		.run_ack_o(run_ack_o), .coef_we_i(coef_we_i), .coef_addr_i(coef_addr_i),
		.coef_data_i(coef_data_i), .state_we_o(state_we_o), .state_addr_o(state_addr_o),
		.state_data_o(state_data_o)
	);

	always #20 clk = ~clk;

	task automatic check_value(input string name, input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			errors++;
			$display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("error: %s", msg);
	endtask

	task automatic read_tests();
		int fd;
		int r;
		int v;
		string tok;
		string line;
		fd = $fopen("tb/kalman_tests.txt", "r");
		if (fd == 0) begin
			report_error("could not open the test data file");
		end else begin
			while (!$feof(fd) && n_tests < MAX_TESTS) begin
				r = $fscanf(fd, "%s", tok);
				if (r != 1)
					break;
				if (tok.substr(0, 0) == "#") begin
					r = $fgets(line, fd);
					continue;
				end
				test_name[n_tests] = tok;
				for (int i = 0; i < N_COEF; i++) begin
					r = $fscanf(fd, "%d", v);
					coef_tab[n_tests][i] = v;
				end
				for (int i = 0; i < SERIES_NUM; i++) begin
					r = $fscanf(fd, "%d", v);
					input_tab[n_tests][i] = v;
				end
				for (int i = 0; i < N_STATE; i++) begin
					r = $fscanf(fd, "%d", v);
					expect_tab[n_tests][i] = v;
				end
				n_tests++;
			end
			$fclose(fd);
		end
	endtask

	task automatic load_coefs(input int t);
		for (int i = 0; i < N_COEF + SERIES_NUM; i++) begin
			@(posedge clk);
			coef_we_i <= 1'b1;
			coef_addr_i <= CF_ADDR_W'(i);
			if (i < N_COEF)
				coef_data_i <= coef_t'(coef_tab[t][i]);
			else
				coef_data_i <= coef_t'(input_tab[t][i - N_COEF]);
		end
		@(posedge clk);
		coef_we_i <= 1'b0;
	endtask

	task automatic run_frame();
		repeat ($urandom_range(3)) @(posedge clk);
		run_req_i <= 1'b1;
		in_frame <= 1'b1;
		frame_writes <= 0;
		@(posedge clk);
		while (!run_ack_o)
			@(posedge clk);
		repeat ($urandom_range(3)) @(posedge clk);
		run_req_i <= 1'b0;
		@(posedge clk);
		while (run_ack_o)
			@(posedge clk);
		in_frame <= 1'b0;
		@(posedge clk);
	endtask

	// Watchdog
	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("** FAIL **");
			$finish;
		end
	end

	// Handshake and state write monitor
	always @(posedge clk) begin
		int series;
		int lo;
		if (!harmonics_rst) begin
			if (run_ack_o && !ack_prev && !run_req_i)
				report_error("run_ack_o rose while run_req_i was low");
			if (!run_ack_o && ack_prev && req_prev)
				report_error("run_ack_o fell before run_req_i fell");
			if (state_we_o) begin
				if (!clear_done) begin
					check_value("clear", 0, int'(state_data_o));
					final_state[state_addr_o] = int'(state_data_o);
					clear_count++;
					if (clear_count == CLEAR_LEN)
						clear_done = 1'b1;
				end else if (!in_frame) begin
					report_error("state write between frames");
				end else begin
					series = frame_writes / WR_PER_SERIES;
					lo = series * STATE_STRIDE * HARMONICS_NUM;
					if (int'(state_addr_o) < lo || int'(state_addr_o) >= lo + 2 * HARMONICS_NUM)
						report_error($sformatf("series %0d wrote outside its range", series));
					if (zero_frame)
						check_value("zero frame write", 0, int'(state_data_o));
					final_state[state_addr_o] = int'(state_data_o);
					frame_writes++;
				end
			end
		end
		ack_prev <= run_ack_o;
		req_prev <= run_req_i;
	end

	initial begin
		clk = 1'b0;
		harmonics_rst = 1'b1;
		run_req_i = 1'b0;
		coef_we_i = 1'b0;
		coef_addr_i = '0;
		coef_data_i = '0;
		checks = 0;
		errors = 0;
		cycles = 0;
		cycle_limit = 0;
		clear_count = 0;
		frame_writes = 0;
		clear_done = 1'b0;
		in_frame = 1'b0;
		zero_frame = 1'b0;
		ack_prev = 1'b0;
		req_prev = 1'b0;
		n_tests = 0;
		void'($urandom(98));
		for (int i = 0; i < N_STATE; i++)
			final_state[i] = NO_WRITE;

		read_tests();
		if (n_tests == 0)
			report_error("no tests were found in the test data file");
		cycle_limit = n_tests * 2 * FRAME_LEN + CLEAR_LEN + 20;

		repeat (10) @(posedge clk);
		harmonics_rst <= 1'b0;
		while (!clear_done)
			@(posedge clk);
		for (int i = 0; i < N_STATE; i++)
			check_value("clear state", 0, final_state[i]);

		for (int t = 0; t < n_tests; t++) begin
			zero_frame = 1'b1;
			for (int i = 0; i < N_STATE; i++)
				if (expect_tab[t][i] != 0)
					zero_frame = 1'b0;
			load_coefs(t);
			// Every address must be written again by this frame
			for (int i = 0; i < N_STATE; i++)
				final_state[i] = NO_WRITE;
			run_frame();
			for (int i = 0; i < N_STATE; i++)
				check_value($sformatf("%s addr %0d", test_name[t], i), expect_tab[t][i],
					final_state[i]);
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0 && n_tests > 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- tb/kalman_tests.txt
# name, then cos sin k1 k2 per harmonic, one input per series,
# then per series x1 x2 for each harmonic in state address order
zero_inputs
65536 0 32768 16384 0 65536 16384 32768 -65536 0 65536 0 65536 0 0 65536 0 -65536 16384 16384
0 0 0 0
0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0
first_step
65536 0 32768 16384 0 65536 16384 32768 -65536 0 65536 0 65536 0 0 65536 0 -65536 16384 16384
1000 -2000 4000 400
500 250 250 500 1000 0 0 1000 250 250
-1000 -500 -500 -1000 -2000 0 0 -2000 -500 -500
2000 1000 1000 2000 4000 0 0 4000 1000 1000
200 100 100 200 400 0 0 400 100 100
persist_step
65536 0 32768 16384 0 65536 16384 32768 -65536 0 65536 0 65536 0 0 65536 0 -65536 16384 16384
1000 -2000 4000 400
1375 687 -63 1125 750 0 0 2750 687 187
-2750 -1375 125 -2250 -1500 0 0 -5500 -1375 -375
5500 2750 -250 4500 3000 0 0 11000 2750 750
550 275 -25 450 300 0 0 1100 275 75
reload_coefs
65536 0 16384 32768 65536 0 16384 32768 65536 0 16384 32768 65536 0 16384 32768 65536 0 16384 32768
3000 -5000 10000 1100
1437 812 -1 1250 812 125 62 2875 749 312
-2625 -1125 250 -2000 -1375 250 125 -5250 -1250 -125
5250 2250 -500 4000 2750 -500 -250 10500 2500 250
550 275 -25 450 300 0 0 1100 275 75

//--- verilog/addr_gen.sv
`timescale 1ns/1ps

module addr_gen import kalman_pkg::*; #(
	parameter int ADDR_W = 6,
	parameter int STRIDE = 2,
	parameter int COMMON_BASE = 0
) (
	input  logic clk,
	input  logic harmonics_rst,
	input  addr_req_t req_i,
	output logic [ADDR_W-1:0] addr_o
);

	// One spare bit so an overrun shows up instead of wrapping
	localparam int PTR_W = ADDR_W + 1;

	logic [PTR_W-1:0] cursor;
	logic [PTR_W-1:0] mark;
	logic [PTR_W-1:0] common;
	logic [PTR_W-1:0] addr_next;

	assign addr_next = req_i.common ? PTR_W'(COMMON_BASE) + common
		: cursor + PTR_W'(req_i.slot);

	always_ff @(posedge clk) begin
		addr_o <= addr_next[ADDR_W-1:0];
		if (harmonics_rst) begin
			cursor <= '0;
			mark <= '0;
			common <= '0;
		end else begin
			case (req_i.cmd)
				AC_NEXT: cursor <= cursor + PTR_W'(STRIDE);
				AC_REWIND: cursor <= mark;
				AC_NEXT_SERIES: begin
					mark <= cursor;
					common <= common + 1'b1;
				end
				AC_RESTART: begin
					cursor <= '0;
					mark <= '0;
					common <= '0;
				end
				default: begin
				end
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (harmonics_rst) !addr_next[ADDR_W]);

endmodule

//--- verilog/addr_stage.sv
`timescale 1ns/1ps

module addr_stage import kalman_pkg::*; #(
	parameter int ST_ADDR_W = 6,
	parameter int CF_ADDR_W = 5,
	parameter int HARMONICS_NUM = 5
) (
	input  logic clk,
	input  logic harmonics_rst,
	input  op_t  op_i,
	output logic [ST_ADDR_W-1:0] st_rd_addr_o,
	output logic [ST_ADDR_W-1:0] st_wr_addr_o,
	output logic [CF_ADDR_W-1:0] cf_rd_addr_o,
	output stage_op_t op_o
);

	addr_gen #(.ADDR_W(ST_ADDR_W), .STRIDE(STATE_STRIDE), .COMMON_BASE(0)) i_st_rd (
		.clk(clk), .harmonics_rst(harmonics_rst), .req_i(op_i.st_rd), .addr_o(st_rd_addr_o)
	);

	addr_gen #(.ADDR_W(ST_ADDR_W), .STRIDE(STATE_STRIDE), .COMMON_BASE(0)) i_st_wr (
		.clk(clk), .harmonics_rst(harmonics_rst), .req_i(op_i.st_wr), .addr_o(st_wr_addr_o)
	);

	// Input samples sit right after the coefficient records
	addr_gen #(
		.ADDR_W(CF_ADDR_W), .STRIDE(COEF_STRIDE), .COMMON_BASE(COEF_STRIDE * HARMONICS_NUM)
	) i_cf_rd (
		.clk(clk), .harmonics_rst(harmonics_rst), .req_i(op_i.cf_rd), .addr_o(cf_rd_addr_o)
	);

	always_ff @(posedge clk) begin
		if (harmonics_rst)
			op_o <= '0;
		else
			op_o <= '{alu: op_i.alu, we: op_i.we};
	end

endmodule

//--- verilog/dp_ram.sv
`timescale 1ns/1ps

module dp_ram import kalman_pkg::*; #(
	parameter int ADDR_W = 6
) (
	input  logic clk,
	input  logic we_i,
	input  logic [ADDR_W-1:0] wr_addr_i,
	input  data_t wr_data_i,
	input  logic [ADDR_W-1:0] rd_addr_i,
	output data_t rd_data_o
);

	data_t mem [2**ADDR_W];

	// Read before write on a shared address
	always_ff @(posedge clk) begin
		if (we_i)
			mem[wr_addr_i] <= wr_data_i;
		rd_data_o <= mem[rd_addr_i];
	end

endmodule

//--- verilog/harmonics_sequencer.sv
`timescale 1ns/1ps

module harmonics_sequencer import kalman_pkg::*; #(
	parameter int HARMONICS_NUM = 5,
	parameter int SERIES_NUM = 4
) (
	input  logic clk,
	input  logic harmonics_rst,
	input  logic run_req_i,
	output logic run_ack_o,
	output op_t  op_o
);

	localparam int HC_W = $clog2(HARMONICS_NUM);
	localparam int SC_W = (SERIES_NUM > 1) ? $clog2(SERIES_NUM) : 1;

	seq_state_t state;
	logic [HC_W-1:0] harm_cnt;
	logic [SC_W-1:0] series_cnt;
	// Sub-step within a harmonic, also counts the drain cycles
	logic [1:0] phase;
	logic last_h;
	logic last_s;
	slot_t pair_slot;
	addr_cmd_t st_step_cmd;

	assign last_h = (harm_cnt == HC_W'(HARMONICS_NUM - 1));
	assign last_s = (series_cnt == SC_W'(SERIES_NUM - 1));
	assign pair_slot = phase[0] ? SLOT_X2 : SLOT_X1;
	assign st_step_cmd = (last_h && last_s) ? AC_RESTART : AC_NEXT;
	assign run_ack_o = (state == SQ_ACK);

	always_ff @(posedge clk) begin
		if (harmonics_rst) begin
			state <= SQ_CLEAR;
			harm_cnt <= '0;
			series_cnt <= '0;
			phase <= '0;
		end else begin
			case (state)
				SQ_CLEAR: begin
					phase <= {1'b0, ~phase[0]};
					if (phase[0]) begin
						harm_cnt <= last_h ? '0 : harm_cnt + 1'b1;
						if (last_h) begin
							series_cnt <= last_s ? '0 : series_cnt + 1'b1;
							if (last_s)
								state <= SQ_IDLE;
						end
					end
				end
				SQ_IDLE: begin
					if (run_req_i)
						state <= SQ_ROTATE;
				end
				SQ_ROTATE: begin
					phase <= phase + 2'd1;
					if (phase == 2'd3) begin
						harm_cnt <= last_h ? '0 : harm_cnt + 1'b1;
						if (last_h)
							state <= SQ_ERROR;
					end
				end
				SQ_ERROR: begin
					state <= SQ_UPDATE;
				end
				SQ_UPDATE: begin
					phase <= {1'b0, ~phase[0]};
					if (phase[0]) begin
						harm_cnt <= last_h ? '0 : harm_cnt + 1'b1;
						if (last_h)
							state <= SQ_SERIES;
					end
				end
				SQ_SERIES: begin
					series_cnt <= last_s ? '0 : series_cnt + 1'b1;
					state <= last_s ? SQ_DRAIN : SQ_ROTATE;
				end
				SQ_DRAIN: begin
					phase <= phase + 2'd1;
					if (phase == 2'(PIPE_DEPTH - 1)) begin
						phase <= '0;
						state <= SQ_ACK;
					end
				end
				default: begin
					if (!run_req_i)
						state <= SQ_IDLE;
				end
			endcase
		end
	end

	always_comb begin
		op_o = '0;
		case (state)
			SQ_CLEAR: begin
				op_o.alu = ALU_CLEAR;
				op_o.we = 1'b1;
				op_o.st_wr.slot = pair_slot;
				if (phase[0])
					op_o.st_wr.cmd = st_step_cmd;
			end
			SQ_ROTATE: begin
				case (phase)
					2'd0: begin
						op_o.alu = ALU_ROT_A;
						op_o.st_rd.slot = SLOT_X1;
						op_o.cf_rd.slot = SLOT_COS;
					end
					2'd1: begin
						op_o.alu = ALU_ROT_B;
						op_o.st_rd.slot = SLOT_X2;
						op_o.cf_rd.slot = SLOT_SIN;
						op_o.st_wr.slot = SLOT_X1;
						op_o.we = 1'b1;
					end
					2'd2: begin
						op_o.alu = ALU_ROT_C;
						op_o.cf_rd.slot = SLOT_SIN;
					end
					default: begin
						op_o.alu = ALU_ROT_D;
						op_o.cf_rd.slot = SLOT_COS;
						op_o.st_wr.slot = SLOT_X2;
						op_o.we = 1'b1;
						// Back to the series base once all harmonics are rotated
						op_o.st_rd.cmd = last_h ? AC_REWIND : AC_NEXT;
						op_o.st_wr.cmd = last_h ? AC_REWIND : AC_NEXT;
						op_o.cf_rd.cmd = last_h ? AC_REWIND : AC_NEXT;
					end
				endcase
			end
			SQ_ERROR: begin
				op_o.alu = ALU_ERROR;
				op_o.cf_rd.common = 1'b1;
			end
			SQ_UPDATE: begin
				op_o.alu = ALU_UPDATE;
				op_o.we = 1'b1;
				op_o.st_rd.slot = pair_slot;
				op_o.st_wr.slot = pair_slot;
				op_o.cf_rd.slot = phase[0] ? SLOT_K2 : SLOT_K1;
				if (phase[0]) begin
					op_o.st_rd.cmd = st_step_cmd;
					op_o.st_wr.cmd = st_step_cmd;
					op_o.cf_rd.cmd = last_h ? AC_REWIND : AC_NEXT;
				end
			end
			SQ_SERIES: begin
				if (last_s) begin
					op_o.cf_rd.cmd = AC_RESTART;
				end else begin
					op_o.st_rd.cmd = AC_NEXT_SERIES;
					op_o.st_wr.cmd = AC_NEXT_SERIES;
					op_o.cf_rd.cmd = AC_NEXT_SERIES;
				end
			end
			default: begin
			end
		endcase
	end

	assert property (@(posedge clk) disable iff (harmonics_rst) $rose(run_ack_o) |-> run_req_i);
	assert property (@(posedge clk) HARMONICS_NUM >= 2);

endmodule

//--- verilog/kalman_harmonics_top.sv
`timescale 1ns/1ps

module kalman_harmonics_top import kalman_pkg::*; #(
	parameter int HARMONICS_NUM = 5,
	parameter int SERIES_NUM = 4,
	localparam int ST_ADDR_W = $clog2(SERIES_NUM * HARMONICS_NUM * STATE_STRIDE),
	localparam int CF_ADDR_W = $clog2(HARMONICS_NUM * COEF_STRIDE + SERIES_NUM)
) (
	input  logic clk,
	input  logic harmonics_rst,
	input  logic run_req_i,
	output logic run_ack_o,
	input  logic coef_we_i,
	input  logic [CF_ADDR_W-1:0] coef_addr_i,
	input  coef_t coef_data_i,
	output logic state_we_o,
	output logic [ST_ADDR_W-1:0] state_addr_o,
	output data_t state_data_o
);

	op_t seq_op;
	stage_op_t stage_op;
	logic [ST_ADDR_W-1:0] st_rd_addr;
	logic [ST_ADDR_W-1:0] st_wr_addr;
	logic [CF_ADDR_W-1:0] cf_rd_addr;
	data_t st_rd_data;
	coef_t cf_rd_data;

	harmonics_sequencer #(.HARMONICS_NUM(HARMONICS_NUM), .SERIES_NUM(SERIES_NUM)) i_seq (
		.clk(clk), .harmonics_rst(harmonics_rst), .run_req_i(run_req_i),
		.run_ack_o(run_ack_o), .op_o(seq_op)
	);

	addr_stage #(
		.ST_ADDR_W(ST_ADDR_W), .CF_ADDR_W(CF_ADDR_W), .HARMONICS_NUM(HARMONICS_NUM)
	) i_addr (
		.clk(clk), .harmonics_rst(harmonics_rst), .op_i(seq_op), .st_rd_addr_o(st_rd_addr),
		.st_wr_addr_o(st_wr_addr), .cf_rd_addr_o(cf_rd_addr), .op_o(stage_op)
	);

	dp_ram #(.ADDR_W(ST_ADDR_W)) i_state_ram (
		.clk(clk), .we_i(state_we_o), .wr_addr_i(state_addr_o), .wr_data_i(state_data_o),
		.rd_addr_i(st_rd_addr), .rd_data_o(st_rd_data)
	);

	// Coefficients and input samples, loaded by the host between frames
	dp_ram #(.ADDR_W(CF_ADDR_W)) i_coef_ram (
		.clk(clk), .we_i(coef_we_i), .wr_addr_i(coef_addr_i), .wr_data_i(coef_data_i),
		.rd_addr_i(cf_rd_addr), .rd_data_o(cf_rd_data)
	);

	rotate_update_alu #(.ST_ADDR_W(ST_ADDR_W)) i_alu (
		.clk(clk), .harmonics_rst(harmonics_rst), .op_i(stage_op), .wr_addr_i(st_wr_addr),
		.state_i(st_rd_data), .coef_i(cf_rd_data), .state_we_o(state_we_o),
		.state_addr_o(state_addr_o), .state_data_o(state_data_o)
	);

endmodule

//--- verilog/kalman_pkg.sv
package kalman_pkg;

	localparam int DATA_W = 18;
	localparam int FRAC_BITS = 16;
	localparam int ACC_W = 37;

	typedef logic signed [DATA_W-1:0] data_t;
	typedef logic signed [DATA_W-1:0] coef_t;
	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic [1:0] slot_t;

	// Offsets inside a state record
	localparam slot_t SLOT_X1 = 2'd0;
	localparam slot_t SLOT_X2 = 2'd1;

	// Offsets inside a coefficient record
	localparam slot_t SLOT_COS = 2'd0;
	localparam slot_t SLOT_SIN = 2'd1;
	localparam slot_t SLOT_K1 = 2'd2;
	localparam slot_t SLOT_K2 = 2'd3;

	localparam int COEF_STRIDE = 4;
	localparam int STATE_STRIDE = 2;
	localparam int PIPE_DEPTH = 3;

	typedef enum logic [2:0] {AC_HOLD, AC_NEXT, AC_REWIND, AC_NEXT_SERIES, AC_RESTART} addr_cmd_t;

	typedef struct packed {
		addr_cmd_t cmd;
		slot_t slot;
		logic common;
	} addr_req_t;

	typedef enum logic [2:0] {
		ALU_NOP, ALU_CLEAR, ALU_ROT_A, ALU_ROT_B, ALU_ROT_C, ALU_ROT_D, ALU_ERROR, ALU_UPDATE
	} alu_op_t;

	typedef struct packed {
		alu_op_t alu;
		addr_req_t st_rd;
		addr_req_t st_wr;
		addr_req_t cf_rd;
		logic we;
	} op_t;

	typedef struct packed {
		alu_op_t alu;
		logic we;
	} stage_op_t;

	typedef enum logic [2:0] {
		SQ_CLEAR, SQ_IDLE, SQ_ROTATE, SQ_ERROR, SQ_UPDATE, SQ_SERIES, SQ_DRAIN, SQ_ACK
	} seq_state_t;

endpackage

//--- verilog/rotate_update_alu.sv
`timescale 1ns/1ps

module rotate_update_alu import kalman_pkg::*; #(
	parameter int ST_ADDR_W = 6
) (
	input  logic clk,
	input  logic harmonics_rst,
	input  stage_op_t op_i,
	input  logic [ST_ADDR_W-1:0] wr_addr_i,
	input  data_t state_i,
	input  coef_t coef_i,
	output logic state_we_o,
	output logic [ST_ADDR_W-1:0] state_addr_o,
	output data_t state_data_o
);

	stage_op_t op_q;
	logic [ST_ADDR_W-1:0] wr_addr_q;
	data_t x1_q;
	data_t x2_q;
	data_t sum_q;
	data_t err_q;
	acc_t acc_q;

	data_t mul_a;
	acc_t prod;
	acc_t rot_full;
	data_t rot_val;
	data_t upd_val;
	data_t wr_val;

	always_comb begin
		mul_a = state_i;
		case (op_q.alu)
			ALU_ROT_C: mul_a = x1_q;
			ALU_ROT_D: mul_a = x2_q;
			ALU_UPDATE: mul_a = err_q;
			default: begin
			end
		endcase
		prod = acc_t'(mul_a) * acc_t'(coef_i);
		// x1*cos - x2*sin, or x1*sin + x2*cos
		rot_full = (op_q.alu == ALU_ROT_B) ? acc_q - prod : acc_q + prod;
		rot_val = data_t'(rot_full >>> FRAC_BITS);
		upd_val = state_i + data_t'(prod >>> FRAC_BITS);
		case (op_q.alu)
			ALU_ROT_B, ALU_ROT_D: wr_val = rot_val;
			ALU_UPDATE: wr_val = upd_val;
			default: wr_val = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		wr_addr_q <= wr_addr_i;
		state_addr_o <= wr_addr_q;
		state_data_o <= wr_val;
		case (op_q.alu)
			ALU_ROT_A: begin
				x1_q <= state_i;
				acc_q <= prod;
			end
			ALU_ROT_B: x2_q <= state_i;
			ALU_ROT_C: acc_q <= prod;
			ALU_ERROR: err_q <= data_t'(coef_i) - sum_q;
			default: begin
			end
		endcase
		if (harmonics_rst) begin
			op_q <= '0;
			state_we_o <= 1'b0;
			sum_q <= '0;
		end else begin
			op_q <= op_i;
			state_we_o <= op_q.we;
			// Prediction builds up from the rotated x1 values
			if (op_q.alu == ALU_ROT_B)
				sum_q <= sum_q + rot_val;
			else if (op_q.alu == ALU_ERROR)
				sum_q <= '0;
		end
	end

	assert property (@(posedge clk) disable iff (harmonics_rst)
		op_q.alu == ALU_CLEAR |=> state_we_o && state_data_o == '0);

endmodule
